/* verilog/ooo_commit_pkg.sv */
// ooo commit path definitions
package ooo_commit_pkg;

  localparam int XLEN     = 32;  // data and address width
  localparam int REG_W    = 5;   // destination register number
  localparam int CB_DEPTH = 8;   // completion buffer entries
  localparam int CB_IDX_W = 3;   // entry index width
  localparam int N_UNITS  = 4;   // result producers

  // arbiter slot order, also the grant bit positions
  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_DIV,
    UNIT_LS
  } unit_t;

  // given at allocation and on alu completion
  typedef enum logic [2:0] {
    KIND_ARITH,
    KIND_BRANCH,
    KIND_JUMP,
    KIND_LOAD,
    KIND_STORE,
    KIND_HALT
  } instr_kind_t;

  // one completion buffer entry as written by a unit
  typedef struct packed {
    logic [CB_IDX_W-1:0] index;   // buffer slot
    logic [REG_W-1:0]    vd;      // destination reg
    logic [XLEN-1:0]     wdata;   // result, link value or epc
    logic [XLEN-1:0]     target;  // redirect address
    logic                wen;
    logic                exception;
    logic                mispredict;  // redirect needed
    logic                taken;
    logic                prediction;
    logic                is_branch;
  } cb_record_t;

endpackage

/* verilog/cb_write_if.sv */
// completion buffer write request
`timescale 1ns/10ps

interface cb_write_if;

  logic                       req;  // unit done level
  ooo_commit_pkg::cb_record_t rec;  // formatted result
  logic                       ack;  // pulse in the write cycle

  // unit side, holds req and rec until ack
  modport producer (
    output req,
    output rec,
    input  ack
  );

  modport arbiter (
    input  req,
    input  rec,
    output ack
  );

endinterface

/* verilog/ooo_commit_stage.sv */
// commit record formatting
`timescale 1ns/10ps

module ooo_commit_stage (
  input  logic                                CLK,
  input  logic                                nRST,
  // alu result
  input  logic                                alu_done,
  input  ooo_commit_pkg::instr_kind_t         alu_kind,
  input  logic [ooo_commit_pkg::CB_IDX_W-1:0] alu_index,
  input  logic [ooo_commit_pkg::REG_W-1:0]    alu_vd,
  input  logic [ooo_commit_pkg::XLEN-1:0]     alu_result,
  input  logic [ooo_commit_pkg::XLEN-1:0]     alu_pc,
  input  logic [ooo_commit_pkg::XLEN-1:0]     alu_jump_addr,
  input  logic [ooo_commit_pkg::XLEN-1:0]     alu_br_addr,
  input  logic                                alu_taken,
  input  logic                                alu_prediction,
  input  logic                                alu_exception,
  // multiplier result
  input  logic                                mul_done,
  input  logic [ooo_commit_pkg::CB_IDX_W-1:0] mul_index,
  input  logic [ooo_commit_pkg::REG_W-1:0]    mul_vd,
  input  logic [ooo_commit_pkg::XLEN-1:0]     mul_result,
  input  logic [ooo_commit_pkg::XLEN-1:0]     mul_pc,
  input  logic                                mul_exception,
  // divider result
  input  logic                                div_done,
  input  logic [ooo_commit_pkg::CB_IDX_W-1:0] div_index,
  input  logic [ooo_commit_pkg::REG_W-1:0]    div_vd,
  input  logic [ooo_commit_pkg::XLEN-1:0]     div_result,
  input  logic [ooo_commit_pkg::XLEN-1:0]     div_pc,
  input  logic                                div_exception,
  // load/store result
  input  logic                                ls_done,
  input  logic [ooo_commit_pkg::CB_IDX_W-1:0] ls_index,
  input  logic [ooo_commit_pkg::REG_W-1:0]    ls_vd,
  input  logic [ooo_commit_pkg::XLEN-1:0]     ls_result,
  input  logic [ooo_commit_pkg::XLEN-1:0]     ls_pc,
  input  logic                                ls_exception,
  output logic                                alu_ack,
  output logic                                mul_ack,
  output logic                                div_ack,
  output logic                                ls_ack,
  cb_write_if.producer                        cbw_alu,
  cb_write_if.producer                        cbw_mul,
  cb_write_if.producer                        cbw_div,
  cb_write_if.producer                        cbw_ls
);

  ooo_commit_pkg::cb_record_t              alu_rec;
  logic [ooo_commit_pkg::XLEN-1:0]         alu_pc4;
  logic                                    is_br, is_jmp;
  logic                                    br_mispred, mal_target, alu_exc;
  logic [ooo_commit_pkg::N_UNITS-1:0]      done_v, ack_v;
  logic [ooo_commit_pkg::N_UNITS-1:0]      last_ack;  // last granted unit

  // mul, div and ls all format the same way
  function automatic ooo_commit_pkg::cb_record_t fmt_unit(
    input logic [ooo_commit_pkg::CB_IDX_W-1:0] index,
    input logic [ooo_commit_pkg::REG_W-1:0]    vd,
    input logic [ooo_commit_pkg::XLEN-1:0]     result,
    input logic [ooo_commit_pkg::XLEN-1:0]     pc,
    input logic                                exception
  );
    ooo_commit_pkg::cb_record_t r;
    r           = '0;
    r.index     = index;
    r.vd        = vd;
    r.wdata     = exception ? pc : result;  // epc rides in wdata
    r.target    = pc + 32'd4;
    r.wen       = ~exception;
    r.exception = exception;
    return r;
  endfunction

  assign is_br      = alu_kind == ooo_commit_pkg::KIND_BRANCH;
  assign is_jmp     = alu_kind == ooo_commit_pkg::KIND_JUMP;
  assign alu_pc4    = alu_pc + 32'd4;  // link value
  assign br_mispred = alu_prediction ^ alu_taken;
  assign mal_target = (is_jmp && alu_jump_addr[1:0] != 2'b00) ||
                      (is_br && alu_br_addr[1:0] != 2'b00);  // not word aligned
  assign alu_exc    = alu_exception | mal_target;

  always_comb begin
    alu_rec            = '0;
    alu_rec.index      = alu_index;
    alu_rec.vd         = alu_vd;
    alu_rec.wdata      = alu_exc ? alu_pc : (is_jmp ? alu_pc4 : alu_result);
    alu_rec.mispredict = is_br ? br_mispred : is_jmp;  // jumps always redirect
    if (is_br && br_mispred)
      alu_rec.target = alu_br_addr;  // resolved target
    else if (is_jmp)
      alu_rec.target = alu_jump_addr;
    else
      alu_rec.target = alu_pc4;
    alu_rec.wen        = ~(is_br | alu_exc);  // branches write nothing
    alu_rec.exception  = alu_exc;
    alu_rec.taken      = alu_taken;
    alu_rec.prediction = alu_prediction;
    alu_rec.is_branch  = is_br;
  end

  assign cbw_alu.req = alu_done;
  assign cbw_alu.rec = alu_rec;
  assign cbw_mul.req = mul_done;
  assign cbw_mul.rec = fmt_unit(mul_index, mul_vd, mul_result, mul_pc, mul_exception);
  assign cbw_div.req = div_done;
  assign cbw_div.rec = fmt_unit(div_index, div_vd, div_result, div_pc, div_exception);
  assign cbw_ls.req  = ls_done;
  assign cbw_ls.rec  = fmt_unit(ls_index, ls_vd, ls_result, ls_pc, ls_exception);

  // acks back to the units
  assign alu_ack = cbw_alu.ack;
  assign mul_ack = cbw_mul.ack;
  assign div_ack = cbw_div.ack;
  assign ls_ack  = cbw_ls.ack;

  assign done_v = {ls_done, div_done, mul_done, alu_done};  // unit_t bit order
  assign ack_v  = {cbw_ls.ack, cbw_div.ack, cbw_mul.ack, cbw_alu.ack};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      last_ack <= '0;
    else if (|ack_v)
      last_ack <= ack_v;  // held across idle cycles like the rr pointer
  end

  // arbiter only acks a unit that is done
  a_ack_done: assert property (@(posedge CLK) disable iff (!nRST)
    (ack_v & ~done_v) == '0);
  // same unit twice in a row only when nobody else was waiting
  a_rr_fair: assert property (@(posedge CLK) disable iff (!nRST)
    (ack_v & last_ack) != '0 |-> (done_v & ~last_ack) == '0);

endmodule

/* verilog/cb_write_arbiter.sv */
// round-robin completion buffer write arbiter
`timescale 1ns/10ps

module cb_write_arbiter (
  input  logic                       CLK,
  input  logic                       nRST,
  cb_write_if.arbiter                s_alu,
  cb_write_if.arbiter                s_mul,
  cb_write_if.arbiter                s_div,
  cb_write_if.arbiter                s_ls,
  output logic                       wr_en,
  output ooo_commit_pkg::cb_record_t wr_rec
);

  logic [ooo_commit_pkg::N_UNITS-1:0] req_v, gnt_v;
  ooo_commit_pkg::cb_record_t         rec_v [ooo_commit_pkg::N_UNITS];
  ooo_commit_pkg::unit_t              ptr;  // highest priority slot
  ooo_commit_pkg::unit_t              win;

  assign req_v = {s_ls.req, s_div.req, s_mul.req, s_alu.req};

  assign rec_v[ooo_commit_pkg::UNIT_ALU] = s_alu.rec;
  assign rec_v[ooo_commit_pkg::UNIT_MUL] = s_mul.rec;
  assign rec_v[ooo_commit_pkg::UNIT_DIV] = s_div.rec;
  assign rec_v[ooo_commit_pkg::UNIT_LS]  = s_ls.rec;

  // scan from the far end so the slot nearest ptr wins
  always_comb begin
    logic [1:0] cand;
    win   = ptr;
    wr_en = 1'b0;
    for (int k = ooo_commit_pkg::N_UNITS - 1; k >= 0; k--) begin
      cand = ptr + 2'(k);  // wraps mod 4
      if (req_v[cand]) begin
        win   = ooo_commit_pkg::unit_t'(cand);
        wr_en = 1'b1;
      end
    end
  end

  assign gnt_v  = wr_en ? (4'b0001 << win) : '0;  // one-hot
  assign wr_rec = rec_v[win];

  assign s_alu.ack = gnt_v[ooo_commit_pkg::UNIT_ALU];
  assign s_mul.ack = gnt_v[ooo_commit_pkg::UNIT_MUL];
  assign s_div.ack = gnt_v[ooo_commit_pkg::UNIT_DIV];
  assign s_ls.ack  = gnt_v[ooo_commit_pkg::UNIT_LS];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      ptr <= ooo_commit_pkg::UNIT_ALU;
    else if (wr_en)
      ptr <= ooo_commit_pkg::unit_t'(win + 2'd1);  // winner's successor
  end

  a_gnt_onehot: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0(gnt_v) && ((gnt_v & ~req_v) == '0));

endmodule

/* verilog/completion_buffer.sv */
// in-order completion buffer
`timescale 1ns/10ps

module completion_buffer (
  input  logic                                CLK,
  input  logic                                nRST,
  // allocation from decode
  input  logic                                alloc_req,
  input  logic [ooo_commit_pkg::REG_W-1:0]    alloc_vd,
  input  ooo_commit_pkg::instr_kind_t         alloc_kind,
  output logic [ooo_commit_pkg::CB_IDX_W-1:0] alloc_index,
  output logic                                full,
  // single write port
  input  logic                                wr_en,
  input  ooo_commit_pkg::cb_record_t          wr_rec,
  // retire
  output logic                                retire_valid,
  output logic                                rf_wen,
  output logic [ooo_commit_pkg::REG_W-1:0]    rf_vd,
  output logic [ooo_commit_pkg::XLEN-1:0]     rf_wdata,
  output logic                                retire_exception,
  output logic [ooo_commit_pkg::XLEN-1:0]     retire_epc,
  output logic                                redirect,
  output logic [ooo_commit_pkg::XLEN-1:0]     redirect_addr,
  output logic                                halted,
  // predictor update
  output logic                                pred_update,
  output logic                                pred_taken,
  output logic                                pred_prediction,
  output logic [ooo_commit_pkg::XLEN-1:0]     pred_addr
);

  ooo_commit_pkg::cb_record_t          rec_q  [ooo_commit_pkg::CB_DEPTH];
  ooo_commit_pkg::instr_kind_t         kind_q [ooo_commit_pkg::CB_DEPTH];
  logic [ooo_commit_pkg::REG_W-1:0]    vd_q   [ooo_commit_pkg::CB_DEPTH];
  logic [ooo_commit_pkg::CB_DEPTH-1:0] ready_q;
  logic [ooo_commit_pkg::CB_IDX_W-1:0] head, tail;
  logic [ooo_commit_pkg::CB_IDX_W:0]   count;  // one extra bit for full
  logic [ooo_commit_pkg::CB_IDX_W-1:0] wr_off;
  logic                                wr_alloc, alloc_do, head_halt;
  ooo_commit_pkg::cb_record_t          head_rec;

  assign alloc_index = tail;
  assign full        = count[ooo_commit_pkg::CB_IDX_W];  // depth is a power of two
  assign alloc_do    = alloc_req & ~full & ~halted;      // dropped while full

  // slot lies between head and tail
  assign wr_off   = wr_rec.index - head;
  assign wr_alloc = {1'b0, wr_off} < count;

  assign head_rec     = rec_q[head];
  assign head_halt    = kind_q[head] == ooo_commit_pkg::KIND_HALT;
  assign retire_valid = (count != '0) & ready_q[head] & ~halted;

  assign rf_wen           = retire_valid & head_rec.wen;
  assign rf_vd            = vd_q[head];
  assign rf_wdata         = head_rec.wdata;
  assign retire_exception = retire_valid & head_rec.exception;
  assign retire_epc       = head_rec.wdata;  // pc stored on exception
  assign redirect         = retire_valid & (head_rec.mispredict | head_rec.exception);
  assign redirect_addr    = head_rec.target;

  assign pred_update     = retire_valid & head_rec.is_branch;
  assign pred_taken      = head_rec.taken;
  assign pred_prediction = head_rec.prediction;
  assign pred_addr       = head_rec.target;

  // payload, no reset
  always_ff @(posedge CLK) begin
    if (wr_en)
      rec_q[wr_rec.index] <= wr_rec;
    if (alloc_do) begin
      kind_q[tail] <= alloc_kind;
      vd_q[tail]   <= alloc_vd;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head    <= '0;
      tail    <= '0;
      count   <= '0;
      ready_q <= '0;
      halted  <= 1'b0;
    end else begin
      if (wr_en)
        ready_q[wr_rec.index] <= 1'b1;  // fill in any order
      if (alloc_do) begin
        tail          <= tail + 1'b1;
        ready_q[tail] <= 1'b0;
      end
      if (retire_valid) begin
        head          <= head + 1'b1;
        ready_q[head] <= 1'b0;
        if (head_halt)
          halted <= 1'b1;  // sticky until reset
      end
      // redirect drops every younger entry, incl. one allocated now
      if (redirect) begin
        tail    <= head + 1'b1;
        count   <= '0;
        ready_q <= '0;
      end else begin
        count <= count + alloc_do - retire_valid;
      end
    end
  end

  // units only finish live entries, and only once
  a_wr_slot: assert property (@(posedge CLK) disable iff (!nRST)
    wr_en |-> wr_alloc && !ready_q[wr_rec.index]);
  a_halt_hold: assert property (@(posedge CLK) disable iff (!nRST)
    halted |=> $stable(head) && $stable(tail));

endmodule

/* verilog/ooo_commit_top.sv */
// ooo writeback and commit top
`timescale 1ns/10ps

module ooo_commit_top (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                alu_done,
  input  ooo_commit_pkg::instr_kind_t         alu_kind,
  input  logic [ooo_commit_pkg::CB_IDX_W-1:0] alu_index,
  input  logic [ooo_commit_pkg::REG_W-1:0]    alu_vd,
  input  logic [ooo_commit_pkg::XLEN-1:0]     alu_result,
  input  logic [ooo_commit_pkg::XLEN-1:0]     alu_pc,
  input  logic [ooo_commit_pkg::XLEN-1:0]     alu_jump_addr,
  input  logic [ooo_commit_pkg::XLEN-1:0]     alu_br_addr,
  input  logic                                alu_taken,
  input  logic                                alu_prediction,
  input  logic                                alu_exception,
  input  logic                                mul_done,
  input  logic [ooo_commit_pkg::CB_IDX_W-1:0] mul_index,
  input  logic [ooo_commit_pkg::REG_W-1:0]    mul_vd,
  input  logic [ooo_commit_pkg::XLEN-1:0]     mul_result,
  input  logic [ooo_commit_pkg::XLEN-1:0]     mul_pc,
  input  logic                                mul_exception,
  input  logic                                div_done,
  input  logic [ooo_commit_pkg::CB_IDX_W-1:0] div_index,
  input  logic [ooo_commit_pkg::REG_W-1:0]    div_vd,
  input  logic [ooo_commit_pkg::XLEN-1:0]     div_result,
  input  logic [ooo_commit_pkg::XLEN-1:0]     div_pc,
  input  logic                                div_exception,
  input  logic                                ls_done,
  input  logic [ooo_commit_pkg::CB_IDX_W-1:0] ls_index,
  input  logic [ooo_commit_pkg::REG_W-1:0]    ls_vd,
  input  logic [ooo_commit_pkg::XLEN-1:0]     ls_result,
  input  logic [ooo_commit_pkg::XLEN-1:0]     ls_pc,
  input  logic                                ls_exception,
  output logic                                alu_ack,
  output logic                                mul_ack,
  output logic                                div_ack,
  output logic                                ls_ack,
  input  logic                                alloc_req,
  input  logic [ooo_commit_pkg::REG_W-1:0]    alloc_vd,
  input  ooo_commit_pkg::instr_kind_t         alloc_kind,
  output logic [ooo_commit_pkg::CB_IDX_W-1:0] alloc_index,
  output logic                                full,
  output logic                                retire_valid,
  output logic                                rf_wen,
  output logic [ooo_commit_pkg::REG_W-1:0]    rf_vd,
  output logic [ooo_commit_pkg::XLEN-1:0]     rf_wdata,
  output logic                                retire_exception,
  output logic [ooo_commit_pkg::XLEN-1:0]     retire_epc,
  output logic                                redirect,
  output logic [ooo_commit_pkg::XLEN-1:0]     redirect_addr,
  output logic                                halted,
  output logic                                pred_update,
  output logic                                pred_taken,
  output logic                                pred_prediction,
  output logic [ooo_commit_pkg::XLEN-1:0]     pred_addr
);

  cb_write_if cbw_alu ();
  cb_write_if cbw_mul ();
  cb_write_if cbw_div ();
  cb_write_if cbw_ls ();

  logic                       wr_en;   // arbiter winner valid
  ooo_commit_pkg::cb_record_t wr_rec;

  // port names match one to one
  ooo_commit_stage ooo_commit_stage_i (.*);

  cb_write_arbiter cb_write_arbiter_i (
    .CLK    (CLK),
    .nRST   (nRST),
    .s_alu  (cbw_alu),
    .s_mul  (cbw_mul),
    .s_div  (cbw_div),
    .s_ls   (cbw_ls),
    .wr_en  (wr_en),
    .wr_rec (wr_rec)
  );

  completion_buffer completion_buffer_i (.*);

endmodule

/* test/commit_ref.svh */
// commit reference model
`ifndef COMMIT_REF_SVH
`define COMMIT_REF_SVH

ooo_commit_pkg::cb_record_t  exp_q[$];  // program order, oldest first
ooo_commit_pkg::instr_kind_t kind_q[$];
bit                          halt_seen;  // a halt has retired

// expected record for one unit result
function automatic ooo_commit_pkg::cb_record_t format_record(
  input ooo_commit_pkg::unit_t       u,
  input ooo_commit_pkg::instr_kind_t k,
  input logic [2:0]  idx,
  input logic [4:0]  vd,
  input logic [31:0] result,
  input logic [31:0] pc,
  input logic [31:0] jaddr,
  input logic [31:0] baddr,
  input logic        tk,
  input logic        pr,
  input logic        exc
);
  ooo_commit_pkg::cb_record_t r;
  logic jmp, br, bad;
  r       = '0;
  r.index = idx;
  r.vd    = vd;
  jmp     = (u == ooo_commit_pkg::UNIT_ALU) && (k == ooo_commit_pkg::KIND_JUMP);
  br      = (u == ooo_commit_pkg::UNIT_ALU) && (k == ooo_commit_pkg::KIND_BRANCH);
  bad     = (jmp && jaddr[1:0] != 2'b00) || (br && baddr[1:0] != 2'b00);
  r.exception  = exc | bad;  // misaligned target traps
  r.mispredict = br ? (tk ^ pr) : jmp;
  if (br && r.mispredict)
    r.target = baddr;
  else
    r.target = jmp ? jaddr : pc + 32'd4;
  r.wdata = r.exception ? pc : (jmp ? pc + 32'd4 : result);  // link value on jump
  r.wen   = !(br || r.exception);
  if (u == ooo_commit_pkg::UNIT_ALU) begin
    r.taken      = tk;
    r.prediction = pr;
    r.is_branch  = br;
  end
  return r;
endfunction

// oldest entry, drops the younger ones on a redirect
function automatic void retire_model(output ooo_commit_pkg::cb_record_t r,
                                     output ooo_commit_pkg::instr_kind_t k);
  r = exp_q.pop_front();
  k = kind_q.pop_front();
  if (r.mispredict || r.exception) begin
    exp_q.delete();
    kind_q.delete();
  end
  if (k == ooo_commit_pkg::KIND_HALT)
    halt_seen = 1'b1;  // nothing retires after this
endfunction

`endif

/* test/tb_ooo_commit.sv */
// commit path testbench
`timescale 1ns/10ps

module tb_ooo_commit;

  logic CLK, nRST;
  logic alu_done, alu_taken, alu_prediction, alu_exception;
  ooo_commit_pkg::instr_kind_t alu_kind, alloc_kind;
  logic [2:0] alu_index, mul_index, div_index, ls_index, alloc_index;
  logic [4:0] alu_vd, mul_vd, div_vd, ls_vd, alloc_vd, rf_vd;
  logic [31:0] alu_result, alu_pc, alu_jump_addr, alu_br_addr;
  logic [31:0] mul_result, mul_pc, div_result, div_pc, ls_result, ls_pc;
  logic mul_done, mul_exception, div_done, div_exception, ls_done, ls_exception;
  logic alu_ack, mul_ack, div_ack, ls_ack, alloc_req, full;
  logic retire_valid, rf_wen, retire_exception, redirect, halted;
  logic pred_update, pred_taken, pred_prediction;
  logic [31:0] rf_wdata, retire_epc, redirect_addr, pred_addr;

  // what each slot's unit reports
  ooo_commit_pkg::unit_t       unit_a [8];
  ooo_commit_pkg::instr_kind_t kind_a [8];
  logic [4:0]  vd_a [8];
  logic [31:0] res_a [8], pc_a [8], ja_a [8], ba_a [8];
  logic        tk_a [8], pr_a [8], exc_a [8];
  integer      seed = 32'h28c736ab;
  logic [31:0] pc_next = 32'h0000_1000;
  ooo_commit_pkg::cb_record_t  e_rec, a_rec;
  ooo_commit_pkg::instr_kind_t e_kind;
  int ids[$];
  int s, y;
  logic [2:0] idx0;

  `include "commit_ref.svh"

  ooo_commit_top ooo_commit_top_i (.*);

  always #20 CLK = ~CLK;  // 40 ns period

  task automatic value_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1, "stopped on first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_record(input ooo_commit_pkg::cb_record_t e,
                              input ooo_commit_pkg::cb_record_t a);
    if (a.wen !== e.wen || a.exception !== e.exception)
      value_error($sformatf("retire wen/exc %b%b, expected %b%b",
                            a.wen, a.exception, e.wen, e.exception));
    if (e.wen && (a.vd !== e.vd || a.wdata !== e.wdata))
      value_error($sformatf("rf write x%0d=%h, expected x%0d=%h",
                            a.vd, a.wdata, e.vd, e.wdata));
    if (e.exception && a.wdata !== e.wdata)
      value_error($sformatf("epc %h, expected %h", a.wdata, e.wdata));
  endtask

  task automatic check_redirect(input ooo_commit_pkg::cb_record_t e,
                                input logic rd,
                                input logic [ooo_commit_pkg::XLEN-1:0] addr);
    if (rd !== (e.mispredict | e.exception))
      value_error($sformatf("redirect %b on slot %0d", rd, e.index));
    if (e.mispredict && !e.exception && addr !== e.target)
      value_error($sformatf("redirect to %h, expected %h", addr, e.target));
  endtask

  task automatic check_pred(input ooo_commit_pkg::cb_record_t e,
                            input logic upd, input logic tk, input logic pr,
                            input logic [ooo_commit_pkg::XLEN-1:0] addr);
    if (upd !== e.is_branch)
      value_error($sformatf("pred_update %b, expected %b", upd, e.is_branch));
    if (e.is_branch && (tk !== e.taken || pr !== e.prediction))
      value_error($sformatf("pred taken/prediction %b%b, expected %b%b",
                            tk, pr, e.taken, e.prediction));
    if (e.is_branch && addr !== e.target)
      value_error($sformatf("pred_addr %h, expected %h", addr, e.target));
  endtask

  // compare every retire at negedge where outputs have settled
  always @(negedge CLK) begin
    if (nRST && retire_valid) begin
      if (halt_seen || exp_q.size() == 0)
        value_error("retire with no instruction left to retire");
      retire_model(e_rec, e_kind);
      a_rec           = '0;
      a_rec.wen       = rf_wen;
      a_rec.vd        = rf_vd;
      a_rec.exception = retire_exception;
      a_rec.wdata     = retire_exception ? retire_epc : rf_wdata;
      check_record(e_rec, a_rec);
      check_redirect(e_rec, redirect, redirect_addr);
      check_pred(e_rec, pred_update, pred_taken, pred_prediction, pred_addr);
    end
  end

  task automatic drive_unit(input int i, input logic on);
    case (unit_a[i])
      ooo_commit_pkg::UNIT_ALU: begin
        alu_done       <= on;
        alu_kind       <= kind_a[i];
        alu_index      <= 3'(i);
        alu_vd         <= vd_a[i];
        alu_result     <= res_a[i];
        alu_pc         <= pc_a[i];
        alu_jump_addr  <= ja_a[i];
        alu_br_addr    <= ba_a[i];
        alu_taken      <= tk_a[i];
        alu_prediction <= pr_a[i];
        alu_exception  <= exc_a[i];
      end
      ooo_commit_pkg::UNIT_MUL: begin
        mul_done      <= on;
        mul_index     <= 3'(i);
        mul_vd        <= vd_a[i];
        mul_result    <= res_a[i];
        mul_pc        <= pc_a[i];
        mul_exception <= exc_a[i];
      end
      ooo_commit_pkg::UNIT_DIV: begin
        div_done      <= on;
        div_index     <= 3'(i);
        div_vd        <= vd_a[i];
        div_result    <= res_a[i];
        div_pc        <= pc_a[i];
        div_exception <= exc_a[i];
      end
      default: begin
        ls_done      <= on;
        ls_index     <= 3'(i);
        ls_vd        <= vd_a[i];
        ls_result    <= res_a[i];
        ls_pc        <= pc_a[i];
        ls_exception <= exc_a[i];
      end
    endcase
  endtask

  // allocate one entry and store what its unit will report
  task automatic alloc(input ooo_commit_pkg::unit_t u, input ooo_commit_pkg::instr_kind_t k,
                       input logic exc, input logic [31:0] ja, input logic [31:0] ba,
                       input logic tk, input logic pr, output int i);
    logic [4:0] vd;
    vd = 5'($random(seed));
    @(posedge CLK);
    alloc_req  <= 1'b1;
    alloc_vd   <= vd;
    alloc_kind <= k;
    @(negedge CLK);
    if (full)
      abort_run("buffer full during a normal allocation");
    i = alloc_index;
    unit_a[i] = u;
    kind_a[i] = k;
    vd_a[i]   = vd;
    res_a[i]  = $random(seed);
    pc_a[i]   = pc_next;
    ja_a[i]   = ja;
    ba_a[i]   = ba;
    tk_a[i]   = tk;
    pr_a[i]   = pr;
    exc_a[i]  = exc;
    pc_next += 32'd4;
    exp_q.push_back(format_record(u, k, 3'(i), vd, res_a[i], pc_a[i], ja, ba, tk, pr, exc));
    kind_q.push_back(k);
    @(posedge CLK);  // entry exists after this edge
    alloc_req <= 1'b0;
  endtask

  // raise done on a set of units and collect each ack once
  task automatic complete_group(input int grp[$]);
    int pend[$];
    int acked[$];
    int n;
    logic [3:0] acks, mask;
    pend = grp;
    n    = 0;
    @(posedge CLK);
    foreach (grp[i])
      drive_unit(grp[i], 1'b1);
    while (pend.size() > 0) begin
      if (n == 4)
        abort_run("timeout, a done unit was not acknowledged within 4 cycles");
      @(negedge CLK);
      acks = {ls_ack, div_ack, mul_ack, alu_ack};
      mask = '0;
      foreach (pend[i])
        mask[unit_a[pend[i]]] = 1'b1;
      if ((acks & ~mask) != '0)
        abort_run("acknowledge to a unit that was not done");
      acked.delete();
      for (int i = pend.size() - 1; i >= 0; i--) begin
        if (acks[unit_a[pend[i]]]) begin
          acked.push_back(pend[i]);
          pend.delete(i);
        end
      end
      @(posedge CLK);
      foreach (acked[i])
        drive_unit(acked[i], 1'b0);  // drop done after the edge
      n++;
    end
  endtask

  task automatic complete_one(input int i);
    int g[$];
    g.push_back(i);
    complete_group(g);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      if (n == 40)
        abort_run("timeout waiting for expected instructions to retire");
      @(posedge CLK);
      n++;
    end
  endtask

  task automatic shuffle(ref int q[$]);
    int j, t;
    for (int i = q.size() - 1; i > 0; i--) begin
      j    = $unsigned($random(seed)) % (i + 1);
      t    = q[i];
      q[i] = q[j];
      q[j] = t;
    end
  endtask

  // redirecting entry with a younger one that finishes first
  task automatic redirect_case(input ooo_commit_pkg::unit_t u,
                               input ooo_commit_pkg::instr_kind_t k, input logic exc,
                               input logic [31:0] ja, input logic [31:0] ba,
                               input logic tk, input logic pr);
    int r, yg;
    alloc(u, k, exc, ja, ba, tk, pr, r);
    alloc(ooo_commit_pkg::UNIT_MUL, ooo_commit_pkg::KIND_ARITH, 1'b0, '0, '0, 0, 0, yg);
    complete_one(yg);
    complete_one(r);
    drain();
  endtask

  initial begin
    CLK            = 0;
    nRST           = 0;
    alloc_req      = 0;
    alloc_vd       = '0;
    alloc_kind     = ooo_commit_pkg::KIND_ARITH;
    alu_done       = 0;
    alu_kind       = ooo_commit_pkg::KIND_ARITH;
    alu_index      = '0;
    alu_vd         = '0;
    alu_result     = '0;
    alu_pc         = '0;
    alu_jump_addr  = '0;
    alu_br_addr    = '0;
    alu_taken      = 0;
    alu_prediction = 0;
    alu_exception  = 0;
    mul_done       = 0;
    mul_index      = '0;
    mul_vd         = '0;
    mul_result     = '0;
    mul_pc         = '0;
    mul_exception  = 0;
    div_done       = 0;
    div_index      = '0;
    div_vd         = '0;
    div_result     = '0;
    div_pc         = '0;
    div_exception  = 0;
    ls_done        = 0;
    ls_index       = '0;
    ls_vd          = '0;
    ls_result      = '0;
    ls_pc          = '0;
    ls_exception   = 0;
    halt_seen      = 0;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    if (retire_valid || rf_wen || halted || full || redirect || pred_update ||
        alu_ack || mul_ack || div_ack || ls_ack)
      abort_run("outputs not idle after reset");

    // out of order completion over random units
    ids.delete();
    for (int n = 0; n < 6; n++) begin
      alloc(ooo_commit_pkg::unit_t'($random(seed) & 3), ooo_commit_pkg::KIND_ARITH,
            1'b0, '0, '0, 0, 0, s);
      ids.push_back(s);
    end
    shuffle(ids);
    foreach (ids[i])
      complete_one(ids[i]);
    drain();

    // jumps, branches and exceptions
    redirect_case(ooo_commit_pkg::UNIT_ALU, ooo_commit_pkg::KIND_JUMP, 0, 32'h800, '0, 0, 0);
    redirect_case(ooo_commit_pkg::UNIT_ALU, ooo_commit_pkg::KIND_BRANCH, 0, '0, 32'h440, 1, 0);
    redirect_case(ooo_commit_pkg::UNIT_ALU, ooo_commit_pkg::KIND_BRANCH, 0, '0, 32'h480, 1, 1);
    redirect_case(ooo_commit_pkg::UNIT_DIV, ooo_commit_pkg::KIND_ARITH, 1, '0, '0, 0, 0);
    redirect_case(ooo_commit_pkg::UNIT_LS, ooo_commit_pkg::KIND_LOAD, 1, '0, '0, 0, 0);
    redirect_case(ooo_commit_pkg::UNIT_ALU, ooo_commit_pkg::KIND_JUMP, 0, 32'h802, '0, 0, 0);
    redirect_case(ooo_commit_pkg::UNIT_ALU, ooo_commit_pkg::KIND_BRANCH, 0, '0, 32'h441, 0, 1);

    // all four units at once
    ids.delete();
    for (int u = 0; u < 4; u++) begin
      alloc(ooo_commit_pkg::unit_t'(u), ooo_commit_pkg::KIND_ARITH, 0, '0, '0, 0, 0, s);
      ids.push_back(s);
    end
    complete_group(ids);
    drain();

    // fill all eight entries and try one more
    ids.delete();
    for (int n = 0; n < 8; n++) begin
      alloc(ooo_commit_pkg::unit_t'($random(seed) & 3), ooo_commit_pkg::KIND_STORE,
            1'b0, '0, '0, 0, 0, s);
      ids.push_back(s);
    end
    @(negedge CLK);
    idx0 = alloc_index;
    if (!full)
      value_error("full low with eight entries allocated");
    @(posedge CLK);
    alloc_req <= 1'b1;
    @(posedge CLK);
    alloc_req <= 1'b0;
    @(negedge CLK);
    if (alloc_index !== idx0 || !full)
      value_error($sformatf("alloc_index moved to %0d while full", alloc_index));
    shuffle(ids);
    foreach (ids[i])
      complete_one(ids[i]);
    drain();

    // halt with a ready younger entry that must stay
    alloc(ooo_commit_pkg::UNIT_ALU, ooo_commit_pkg::KIND_HALT, 0, '0, '0, 0, 0, s);
    alloc(ooo_commit_pkg::UNIT_MUL, ooo_commit_pkg::KIND_ARITH, 0, '0, '0, 0, 0, y);
    complete_one(y);
    complete_one(s);
    @(negedge CLK);
    for (int n = 0; !halted; n++) begin
      if (n == 20)
        abort_run("timeout waiting for halted after a halt instruction");
      @(negedge CLK);
    end
    @(posedge CLK);
    alloc_req <= 1'b1;  // ignored while halted
    @(posedge CLK);
    alloc_req <= 1'b0;
    repeat (10) @(negedge CLK);
    if (!halted || exp_q.size() != 1)
      value_error("halted dropped or an entry retired after halt");

    $display("Test OK");
    $finish;
  end

endmodule

/* src.f */
+incdir+test
verilog/ooo_commit_pkg.sv
verilog/cb_write_if.sv
verilog/ooo_commit_stage.sv
verilog/cb_write_arbiter.sv
verilog/completion_buffer.sv
verilog/ooo_commit_top.sv
test/tb_ooo_commit.sv

/* Bender.yml */
package:
  name: ooo_commit

sources:
  - files:
      - verilog/ooo_commit_pkg.sv
      - verilog/cb_write_if.sv
      - verilog/ooo_commit_stage.sv
      - verilog/cb_write_arbiter.sv
      - verilog/completion_buffer.sv
      - verilog/ooo_commit_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_ooo_commit.sv
